// ==== design/freq_synth_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Frequency synthesizer shared definitions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package freq_synth_pkg;

  // Word widths
  localparam int unsigned fs_data_w     = 32;
  localparam int unsigned fs_resolution = 8;

  // Full-scale range and the size of one code step
  localparam int unsigned fs_freq_range = 100_000_000;
  localparam int unsigned fs_scale      = fs_freq_range / (2 ** fs_resolution);
  localparam int unsigned fs_code_max   = (2 ** fs_resolution) - 1;

  // Register map
  typedef enum logic [1:0] {
    fs_addr_ref     = 2'd0,
    fs_addr_target  = 2'd1,
    fs_addr_divider = 2'd2,
    fs_addr_synth   = 2'd3
  } fs_reg_addr_e;

  // Request as written by software
  typedef struct packed {
    logic [fs_data_w-1:0] ref_freq;
    logic [fs_data_w-1:0] target_freq;
  } fs_request_t;

  // Results of one computation
  typedef struct packed {
    logic [fs_data_w-1:0]     divider_value;
    logic [fs_data_w-1:0]     synth_freq;
    logic [fs_resolution-1:0] synth_code;
    logic                     fault;
  } fs_result_t;

endpackage

`default_nettype wire

// ==== design/udiv_seq.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Serial restoring unsigned divider
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module udiv_seq (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 start,
  input  logic [freq_synth_pkg::fs_data_w-1:0] dividend,
  input  logic [freq_synth_pkg::fs_data_w-1:0] divisor,
  output logic [freq_synth_pkg::fs_data_w-1:0] quotient,
  output logic [freq_synth_pkg::fs_data_w-1:0] remainder,
  output logic                                 done
);

  import freq_synth_pkg::*;

  logic                 running;
  logic [5:0]           count;
  logic [fs_data_w-1:0] rem_q;
  logic [fs_data_w-1:0] quo_q;
  logic [fs_data_w-1:0] divisor_q;
  logic [fs_data_w:0]   shifted;
  logic [fs_data_w-1:0] trial;
  logic                 fits;

  // Bring down the next dividend bit and try the subtraction
  assign shifted = {rem_q, quo_q[fs_data_w-1]};
  assign fits    = (shifted >= {1'b0, divisor_q});
  // Only taken when it fits, so the low bits are the whole difference
  assign trial   = shifted[fs_data_w-1:0] - divisor_q;

  // Iteration counter and done pulse
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      running <= 1'b0;
      count   <= '0;
      done    <= 1'b0;
    end else begin
      done <= 1'b0;
      if (!running) begin
        if (start) begin
          running <= 1'b1;
          count   <= 6'(fs_data_w);
        end
      end else begin
        count <= count - 6'd1;
        if (count == 6'd1) begin
          running <= 1'b0;
          done    <= 1'b1;
        end
      end
    end
  end

  // Quotient bits shift in as the dividend bits shift out
  always_ff @(posedge clk) begin
    if (!running && start) begin
      rem_q     <= '0;
      quo_q     <= dividend;
      divisor_q <= divisor;
    end else if (running) begin
      if (fits) begin
        rem_q <= trial;
        quo_q <= {quo_q[fs_data_w-2:0], 1'b1};
      end else begin
        rem_q <= shifted[fs_data_w-1:0];
        quo_q <= {quo_q[fs_data_w-2:0], 1'b0};
      end
    end
  end

  // Held until the next start
  assign quotient  = quo_q;
  assign remainder = rem_q;

endmodule

`default_nettype wire

// ==== design/freq_synth_cfg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Frequency synthesizer register block
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module freq_synth_cfg (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  logic                                     wr_en,
  input  freq_synth_pkg::fs_reg_addr_e             wr_addr,
  input  logic [freq_synth_pkg::fs_data_w-1:0]     wr_data,
  input  freq_synth_pkg::fs_reg_addr_e             rd_addr,
  output logic [freq_synth_pkg::fs_data_w-1:0]     rd_data,
  output logic                                     launch,
  output freq_synth_pkg::fs_request_t              request,
  input  logic                                     busy,
  input  logic                                     done,
  input  freq_synth_pkg::fs_result_t               result,
  output logic [freq_synth_pkg::fs_resolution-1:0] synth_code,
  output logic                                     fault,
  output logic                                     result_valid
);

  import freq_synth_pkg::*;

  fs_request_t req_q;
  fs_result_t  res_q;
  logic        launch_q;
  logic        valid_q;
  logic        wr_ok;

  // The launch cycle counts as busy, the core samples the request then
  assign wr_ok = wr_en && !busy && !launch_q;

  // Request registers
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_q    <= '0;
      launch_q <= 1'b0;
    end else begin
      launch_q <= 1'b0;
      if (wr_ok) begin
        case (wr_addr)
          fs_addr_ref: begin
            req_q.ref_freq <= wr_data;
          end
          fs_addr_target: begin
            req_q.target_freq <= wr_data;
            launch_q          <= 1'b1;
          end
          // Result registers are read only
          default: ;
        endcase
      end
    end
  end

  // Result capture
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      res_q   <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= done;
      if (done) begin
        res_q <= result;
      end
    end
  end

  // Read data
  always_comb begin
    case (rd_addr)
      fs_addr_ref:     rd_data = req_q.ref_freq;
      fs_addr_target:  rd_data = req_q.target_freq;
      fs_addr_divider: rd_data = res_q.divider_value;
      default:         rd_data = res_q.synth_freq;
    endcase
  end

  assign launch       = launch_q;
  assign request      = req_q;
  assign synth_code   = res_q.synth_code;
  assign fault        = res_q.fault;
  assign result_valid = valid_q;

endmodule

`default_nettype wire

// ==== design/freq_synth_core.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Frequency synthesizer division sequencer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module freq_synth_core (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 launch,
  input  freq_synth_pkg::fs_request_t          request,
  output logic                                 busy,
  output logic                                 done,
  output freq_synth_pkg::fs_result_t           result,
  output logic                                 div_start,
  output logic [freq_synth_pkg::fs_data_w-1:0] dividend,
  output logic [freq_synth_pkg::fs_data_w-1:0] divisor,
  input  logic                                 div_done,
  input  logic [freq_synth_pkg::fs_data_w-1:0] quotient
);

  import freq_synth_pkg::*;

  typedef enum logic [2:0] {
    st_idle,
    st_quotient,
    st_synth,
    st_code,
    st_finish
  } state_e;

  state_e                   state;
  fs_result_t               res_q;
  logic [fs_resolution-1:0] code_sat;

  // Code saturates once the synthesized frequency passes full scale
  assign code_sat = (quotient > fs_code_max) ? fs_resolution'(fs_code_max)
                                             : quotient[fs_resolution-1:0];

  // Operands of the division owned by the current state
  always_comb begin
    dividend = request.ref_freq;
    divisor  = request.target_freq;
    case (state)
      st_synth: begin
        divisor = res_q.divider_value + fs_data_w'(1);
      end
      st_code: begin
        dividend = res_q.synth_freq;
        divisor  = fs_scale;
      end
      default: ;
    endcase
  end

  // Sequencer
  // Each division state issues its start on entry and waits for div_done
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= st_idle;
      div_start <= 1'b0;
      res_q     <= '0;
    end else begin
      div_start <= 1'b0;
      case (state)
        st_idle: begin
          if (launch) begin
            res_q <= '0;
            // Zero target is screened here, the divider never sees it
            if (request.target_freq == '0) begin
              res_q.fault <= 1'b1;
              state       <= st_finish;
            end else begin
              state     <= st_quotient;
              div_start <= 1'b1;
            end
          end
        end
        st_quotient: begin
          if (div_done) begin
            // Target above reference, divider value would wrap
            if (quotient == '0) begin
              res_q.fault <= 1'b1;
              state       <= st_finish;
            end else begin
              res_q.divider_value <= quotient - fs_data_w'(1);
              state               <= st_synth;
              div_start           <= 1'b1;
            end
          end
        end
        st_synth: begin
          if (div_done) begin
            res_q.synth_freq <= quotient;
            state            <= st_code;
            div_start        <= 1'b1;
          end
        end
        st_code: begin
          if (div_done) begin
            res_q.synth_code <= code_sat;
            state            <= st_finish;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  assign busy   = (state != st_idle);
  assign done   = (state == st_finish);
  assign result = res_q;

endmodule

`default_nettype wire

// ==== design/freq_synth_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Frequency synthesizer top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module freq_synth_top (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  logic                                     wr_en,
  input  freq_synth_pkg::fs_reg_addr_e             wr_addr,
  input  logic [freq_synth_pkg::fs_data_w-1:0]     wr_data,
  input  freq_synth_pkg::fs_reg_addr_e             rd_addr,
  output logic [freq_synth_pkg::fs_data_w-1:0]     rd_data,
  output logic [freq_synth_pkg::fs_resolution-1:0] synth_code,
  output logic                                     fault,
  output logic                                     busy,
  output logic                                     result_valid
);

  import freq_synth_pkg::*;

  logic                 launch;
  fs_request_t          request;
  logic                 done;
  fs_result_t           result;
  logic                 div_start;
  logic [fs_data_w-1:0] dividend;
  logic [fs_data_w-1:0] divisor;
  logic                 div_done;
  logic [fs_data_w-1:0] quotient;

  freq_synth_cfg u_freq_synth_cfg (
    .clk          (clk),
    .rst_n        (rst_n),
    .wr_en        (wr_en),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data),
    .rd_addr      (rd_addr),
    .rd_data      (rd_data),
    .launch       (launch),
    .request      (request),
    .busy         (busy),
    .done         (done),
    .result       (result),
    .synth_code   (synth_code),
    .fault        (fault),
    .result_valid (result_valid)
  );

  freq_synth_core u_freq_synth_core (
    .clk       (clk),
    .rst_n     (rst_n),
    .launch    (launch),
    .request   (request),
    .busy      (busy),
    .done      (done),
    .result    (result),
    .div_start (div_start),
    .dividend  (dividend),
    .divisor   (divisor),
    .div_done  (div_done),
    .quotient  (quotient)
  );

  // Remainder is not needed by any of the three divisions
  udiv_seq u_udiv_seq (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (div_start),
    .dividend  (dividend),
    .divisor   (divisor),
    .quotient  (quotient),
    .remainder (),
    .done      (div_done)
  );

endmodule

`default_nettype wire

// ==== tests/freq_synth_sva.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Frequency synthesizer core assertions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module freq_synth_sva (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       busy,
  input  logic                       done,
  input  freq_synth_pkg::fs_result_t result,
  input  logic                       div_start,
  input  logic                       div_done
);

  import freq_synth_pkg::*;

  logic        div_pending;
  int unsigned fail_count = 0;

  // A division is outstanding from its start until its done
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      div_pending <= 1'b0;
    end else if (div_start) begin
      div_pending <= 1'b1;
    end else if (div_done) begin
      div_pending <= 1'b0;
    end
  end

  start_when_idle: assert property (
    @(posedge clk) disable iff (!rst_n) div_start |-> !div_pending
  ) else begin
    fail_count++;
    $error("div_start issued while a division was outstanding");
  end

  done_single_pulse: assert property (
    @(posedge clk) disable iff (!rst_n) done |=> !done
  ) else begin
    fail_count++;
    $error("done held high for more than one cycle");
  end

  done_while_busy: assert property (
    @(posedge clk) disable iff (!rst_n) done |-> busy
  ) else begin
    fail_count++;
    $error("done raised while the core was idle");
  end

  fault_clears_values: assert property (
    @(posedge clk) disable iff (!rst_n)
      (done && result.fault) |->
        (result.divider_value == '0 && result.synth_freq == '0 && result.synth_code == '0)
  ) else begin
    fail_count++;
    $error("fault result carries nonzero values");
  end

  // At or above full scale the code sits at its largest value
  code_saturated: assert property (
    @(posedge clk) disable iff (!rst_n)
      (done && !result.fault && result.synth_freq >= fs_freq_range) |->
        (result.synth_code == fs_code_max)
  ) else begin
    fail_count++;
    $error("synth_code not saturated for a frequency above full scale");
  end

  result_known: assert property (
    @(posedge clk) disable iff (!rst_n) done |-> !$isunknown(result)
  ) else begin
    fail_count++;
    $error("result has unknown bits on done");
  end

endmodule

bind freq_synth_core freq_synth_sva u_freq_synth_sva (
  .clk       (clk),
  .rst_n     (rst_n),
  .busy      (busy),
  .done      (done),
  .result    (result),
  .div_start (div_start),
  .div_done  (div_done)
);

`default_nettype wire

// ==== tests/freq_synth_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Frequency synthesizer testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module freq_synth_tb;

  import freq_synth_pkg::*;

  localparam int unsigned n_random   = 40;
  // 60 requests of up to 120 cycles each, plus reset and drain
  localparam int unsigned max_cycles = 60 * 120 + 400;

  logic                     clk = 1'b0;
  logic                     rst_n;
  logic                     wr_en;
  fs_reg_addr_e             wr_addr;
  logic [fs_data_w-1:0]     wr_data;
  fs_reg_addr_e             rd_addr;
  logic [fs_data_w-1:0]     rd_data;
  logic [fs_resolution-1:0] synth_code;
  logic                     fault;
  logic                     busy;
  logic                     result_valid;

  fs_result_t           expected_q[$];
  logic [fs_data_w-1:0] cur_ref;
  logic [31:0]          rng_state;
  int unsigned          error_count = 0;
  int unsigned          cycle_count = 0;

  freq_synth_top u_freq_synth_top (
    .clk          (clk),
    .rst_n        (rst_n),
    .wr_en        (wr_en),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data),
    .rd_addr      (rd_addr),
    .rd_data      (rd_data),
    .synth_code   (synth_code),
    .fault        (fault),
    .busy         (busy),
    .result_valid (result_valid)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Expected register contents for one request
  function automatic fs_result_t expected_result(input logic [31:0] ref_freq,
                                                 input logic [31:0] target);
    fs_result_t  r;
    logic [31:0] ratio;
    logic [31:0] code_full;
    r = '0;
    if (target == 0 || target > ref_freq) begin
      r.fault = 1'b1;
    end else begin
      ratio           = ref_freq / target;
      r.divider_value = ratio - 1;
      r.synth_freq    = ref_freq / (r.divider_value + 1);
      code_full       = r.synth_freq / fs_scale;
      r.synth_code    = (code_full > fs_code_max) ? 8'(fs_code_max) : code_full[7:0];
    end
    return r;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    assert (got == want) else begin
      error_count++;
      $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, want);
    end
  endtask

  // Called 10 ns after a rising edge, returns at the same phase
  task automatic write_reg(input fs_reg_addr_e addr, input logic [31:0] data);
    wr_en   = 1'b1;
    wr_addr = addr;
    wr_data = data;
    @(posedge clk);
    #10;
    wr_en = 1'b0;
  endtask

  task automatic wait_result();
    @(posedge clk);
    #10;
    while (!result_valid) begin
      @(posedge clk);
      #10;
    end
  endtask

  task automatic set_ref(input logic [31:0] value);
    write_reg(fs_addr_ref, value);
    cur_ref = value;
  endtask

  task automatic request_target(input logic [31:0] target);
    expected_q.push_back(expected_result(cur_ref, target));
    write_reg(fs_addr_target, target);
    wait_result();
  endtask

  task automatic run_request(input logic [31:0] ref_freq, input logic [31:0] target);
    set_ref(ref_freq);
    request_target(target);
  endtask

  // Cycle limit
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= max_cycles) begin
      $display("timeout after %0d cycles, a result never arrived", cycle_count);
      $display("Result: FAILED");
      $finish;
    end
  end

  initial begin : compare_results
    fs_result_t want;
    rd_addr = fs_addr_divider;
    forever begin
      @(posedge clk);
      #10;
      if (result_valid) begin
        assert (expected_q.size() > 0) else begin
          error_count++;
          $display("result_valid pulsed at %0t with no request outstanding", $time);
        end
        if (expected_q.size() > 0) begin
          want = expected_q.pop_front();
          check_value("synth_code", synth_code, want.synth_code);
          check_value("fault", fault, want.fault);
          rd_addr = fs_addr_divider;
          #1;
          check_value("divider_value", rd_data, want.divider_value);
          rd_addr = fs_addr_synth;
          #1;
          check_value("synth_freq", rd_data, want.synth_freq);
        end
      end
    end
  end

  initial begin : drive_stimulus
    logic [31:0] r_ref;
    logic [31:0] r_tgt;
    int unsigned sva_fails;
    rst_n     = 1'b0;
    wr_en     = 1'b0;
    wr_addr   = fs_addr_ref;
    wr_data   = '0;
    cur_ref   = '0;
    rng_state = 32'h3dff_7089;
    repeat (8) @(posedge clk);
    #10;
    rst_n = 1'b1;
    check_value("synth_code", synth_code, 0);
    check_value("fault", fault, 0);
    check_value("busy", busy, 0);
    check_value("result_valid", result_valid, 0);

    // Exact ratios and rounding down
    run_request(100_000_000, 25_000_000);
    run_request(48_000_000, 12_000_000);
    run_request(100_000_000, 30_000_000);
    run_request(27_000_000, 4_000_000);
    // Faults, each followed by a valid request
    request_target(0);
    request_target(5_000_000);
    request_target(150_000_000);
    run_request(100_000_000, 1_000_000);
    // Code saturation
    run_request(250_000_000, 200_000_000);
    run_request(100_000_000, 100_000_000);

    // Writes during a computation must not disturb it
    set_ref(80_000_000);
    expected_q.push_back(expected_result(cur_ref, 20_000_000));
    write_reg(fs_addr_target, 20_000_000);
    write_reg(fs_addr_target, 7_000_000);
    write_reg(fs_addr_ref, 1_000_000);
    write_reg(fs_addr_target, 0);
    wait_result();
    request_target(16_000_000);

    repeat (n_random) begin
      rng_state = xorshift32(rng_state);
      r_ref     = 32'd1_000_000 + (rng_state % 32'd999_000_000);
      rng_state = xorshift32(rng_state);
      r_tgt     = (r_ref >> (rng_state % 24)) + ((rng_state >> 8) % 97);
      run_request(r_ref, r_tgt);
    end

    repeat (3) @(posedge clk);
    assert (expected_q.size() == 0) else begin
      error_count++;
      $display("%0d expected results never arrived", expected_q.size());
    end
    sva_fails   = u_freq_synth_top.u_freq_synth_core.u_freq_synth_sva.fail_count;
    error_count = error_count + sva_fails;
    $display("errors: %0d total, %0d from assertions", error_count, sva_fails);
    if (error_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
design/freq_synth_pkg.sv
design/udiv_seq.sv
design/freq_synth_cfg.sv
design/freq_synth_core.sv
design/freq_synth_top.sv
tests/freq_synth_sva.sv
tests/freq_synth_tb.sv

// ==== Bender.yml ====
package:
  name: freq_synth

sources:
  - design/freq_synth_pkg.sv
  - design/udiv_seq.sv
  - design/freq_synth_cfg.sv
  - design/freq_synth_core.sv
  - design/freq_synth_top.sv
  - target: test
    files:
      - tests/freq_synth_sva.sv
      - tests/freq_synth_tb.sv
